// ==== rtl/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// word and address widths
`define XLEN        32
`define CSR_ADDR_W  12

// identity values for the read-only registers
`define HART_ID     32'h0000_0000
`define MARCHID     32'h0000_0017

// rv32im, mxl field = 1
`define ISA_CODE    32'h4000_1100

// interrupt bit positions in mip / mie
`define IRQ_M_EXT   11
`define IRQ_MVU     16

// writable interrupt bits: 3, 7, 11, 16
`define MIP_MASK    32'h0001_0888

`endif

// ==== rtl/csr_pkg.sv ====
`include "csr_defines.svh"

package csr_pkg;

    // implemented csr addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS        = 12'h300,
        CSR_MISA           = 12'h301,
        CSR_MIE            = 12'h304,
        CSR_MTVEC          = 12'h305,
        CSR_MEPC           = 12'h341,
        CSR_MCAUSE         = 12'h342,
        CSR_MTVAL          = 12'h343,
        CSR_MIP            = 12'h344,
        CSR_MVU_WBASEPTR   = 12'h7C0,
        CSR_MVU_IBASEPTR   = 12'h7C1,
        CSR_MVU_OBASEPTR   = 12'h7C2,
        CSR_MVU_PRECISION  = 12'h7C3,
        CSR_MVU_QUANT      = 12'h7C4,
        CSR_MVU_COMMAND    = 12'h7C5,
        CSR_MVU_STATUS     = 12'h7C6,
        CSR_MCYCLE         = 12'hB00,
        CSR_MCYCLEH        = 12'hB80,
        CSR_MVENDORID      = 12'hF11,
        CSR_MARCHID        = 12'hF12,
        CSR_MIMPID         = 12'hF13,
        CSR_MHARTID        = 12'hF14
    } csr_addr_e;

    typedef enum logic [2:0] {
        CSR_OP_NONE  = 3'd0,
        CSR_OP_RW    = 3'd1,
        CSR_OP_SET   = 3'd2,
        CSR_OP_CLEAR = 3'd3,
        CSR_OP_MRET  = 3'd4
    } csr_op_e;

    // mstatus, machine-mode fields only
    typedef struct packed {
        logic        sd;
        logic [17:0] rsvd_hi;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_mid;
        logic        mpie;
        logic [2:0]  rsvd_lo;
        logic        mie;
        logic [2:0]  rsvd_low;
    } mstatus_fields_t;

    typedef union packed {
        mstatus_fields_t    fields;
        logic [`XLEN-1:0]   raw;
    } mstatus_u;

endpackage

// ==== rtl/csr_access_if.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

// one decoded csr access, decoder to register blocks
interface csr_access_if
    import csr_pkg::*;
();

    csr_addr_e          addr;
    logic [`XLEN-1:0]   wdata;
    logic               we;
    logic               re;
    logic               mret;

    modport master (
        output addr, wdata, we, re, mret
    );

    modport slave (
        input  addr, wdata, we, re, mret
    );

endinterface

// ==== rtl/csr_op_decode.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_op_decode import csr_pkg::*; (
    input  csr_op_e             op_i,
    input  csr_addr_e           addr_i,
    input  logic [`XLEN-1:0]    operand_i,
    input  logic [`XLEN-1:0]    rdata_i,
    csr_access_if.master        acc
);

    assign acc.addr = addr_i;

    // ========================================
    // strobes
    // ========================================
    // kept apart from the data path so the
    // read data feedback forms no loop
    always_comb begin
        acc.we   = 1'b0;
        acc.re   = 1'b0;
        acc.mret = 1'b0;
        case (op_i)
            CSR_OP_RW, CSR_OP_SET, CSR_OP_CLEAR: begin
                acc.we = 1'b1;
                acc.re = 1'b1;
            end
            CSR_OP_MRET: begin
                acc.mret = 1'b1;
            end
            default: begin
                acc.we = 1'b0;
            end
        endcase
    end

    // ========================================
    // write data
    // ========================================
    always_comb begin
        case (op_i)
            // read-modify-write against the current value
            CSR_OP_SET:   acc.wdata = operand_i | rdata_i;
            CSR_OP_CLEAR: acc.wdata = rdata_i & ~operand_i;
            default:      acc.wdata = operand_i;
        endcase
    end

endmodule

// ==== rtl/machine_csr_regs.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module machine_csr_regs import csr_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    csr_access_if.slave         acc,
    input  logic [`XLEN-1:0]    boot_addr_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  logic [4:0]          cause_i,
    input  logic                irq_i,
    input  logic                mvu_irq_i,
    input  logic                count_en_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic                hit_o,
    output logic                irq_valid_o,
    output logic [`XLEN-1:0]    irq_target_o
);

    // mie, mpie and mpp
    localparam logic [`XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;

    mstatus_u           mstatus_q, mstatus_d;
    logic [`XLEN-1:0]   mie_q, mie_d;
    logic [`XLEN-1:0]   mip_q, mip_d;
    logic [`XLEN-1:0]   mtvec_q, mtvec_d;
    logic [`XLEN-1:0]   mepc_q, mepc_d;
    logic [`XLEN-1:0]   mcause_q, mcause_d;
    logic [`XLEN-1:0]   mtval_q, mtval_d;
    logic [63:0]        mcycle_q;
    logic               irq_taken;
    logic               epc_captured_q, epc_captured_d;
    logic               boot_load_q;
    logic               mip_we;

    // ========================================
    // read port
    // ========================================
    always_comb begin
        hit_o   = 1'b1;
        rdata_o = '0;
        case (acc.addr)
            CSR_MSTATUS:    rdata_o = mstatus_q.raw;
            CSR_MISA:       rdata_o = `ISA_CODE;
            CSR_MIE:        rdata_o = mie_q;
            CSR_MTVEC:      rdata_o = mtvec_q;
            CSR_MEPC:       rdata_o = mepc_q;
            CSR_MCAUSE:     rdata_o = mcause_q;
            CSR_MTVAL:      rdata_o = mtval_q;
            CSR_MIP:        rdata_o = mip_q;
            CSR_MCYCLE:     rdata_o = mcycle_q[31:0];
            CSR_MCYCLEH:    rdata_o = mcycle_q[63:32];
            CSR_MARCHID:    rdata_o = `MARCHID;
            CSR_MHARTID:    rdata_o = `HART_ID;
            // vendor and impl id are not implemented
            CSR_MVENDORID, CSR_MIMPID: rdata_o = '0;
            default:        hit_o = 1'b0;
        endcase
    end

    // ========================================
    // write, trap entry and return
    // ========================================
    assign irq_taken = mstatus_q.fields.mie & mip_q[`IRQ_MVU] & mie_q[`IRQ_MVU];
    assign mip_we    = acc.we && (acc.addr == CSR_MIP);

    always_comb begin
        mstatus_d      = mstatus_q;
        mie_d          = mie_q;
        mip_d          = mip_q;
        mtvec_d        = boot_load_q ? boot_addr_i : mtvec_q;
        mepc_d         = mepc_q;
        mcause_d       = mcause_q;
        mtval_d        = mtval_q;
        epc_captured_d = epc_captured_q;

        // misa, mcause, counters and id registers ignore writes
        if (acc.we) begin
            case (acc.addr)
                CSR_MSTATUS: mstatus_d.raw = acc.wdata & MSTATUS_WMASK;
                CSR_MIE:     mie_d = (mie_q & ~`MIP_MASK) | (acc.wdata & `MIP_MASK);
                CSR_MTVEC:   mtvec_d = acc.wdata;
                CSR_MEPC:    mepc_d = {acc.wdata[`XLEN-1:1], 1'b0};
                CSR_MTVAL:   mtval_d = acc.wdata;
                CSR_MIP:     mip_d = (mip_q & ~`MIP_MASK) | (acc.wdata & `MIP_MASK);
                default:     mtval_d = mtval_q;
            endcase
        end

        // external line is a level, mvu bit holds until software clears it
        mip_d[`IRQ_M_EXT] = irq_i;
        mip_d[`IRQ_MVU]   = mip_we ? acc.wdata[`IRQ_MVU] : (mip_q[`IRQ_MVU] | mvu_irq_i);

        if (irq_taken) begin
            mcause_d              = {1'b1, 26'b0, cause_i};
            mstatus_d.fields.mpie = mstatus_q.fields.mie;
            // mepc only on the first cycle
            if (!epc_captured_q) begin
                mepc_d         = pc_i;
                epc_captured_d = 1'b1;
            end
        end

        if (acc.mret) begin
            mstatus_d.fields.mie  = mstatus_q.fields.mpie;
            mstatus_d.fields.mpie = 1'b1;
            epc_captured_d        = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q      <= '0;
            mie_q          <= '0;
            mip_q          <= '0;
            mtvec_q        <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            mtval_q        <= '0;
            epc_captured_q <= 1'b0;
            boot_load_q    <= 1'b1;
        end else begin
            mstatus_q      <= mstatus_d;
            mie_q          <= mie_d;
            mip_q          <= mip_d;
            mtvec_q        <= mtvec_d;
            mepc_q         <= mepc_d;
            mcause_q       <= mcause_d;
            mtval_q        <= mtval_d;
            epc_captured_q <= epc_captured_d;
            boot_load_q    <= 1'b0;
        end
    end

    // free-running cycle counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcycle_q <= '0;
        end else if (count_en_i) begin
            mcycle_q <= mcycle_q + 64'd1;
        end
    end

    // ========================================
    // interrupt outputs
    // ========================================
    assign irq_valid_o = mstatus_q.fields.mie & (|mip_q);

    // mret wins so the return target shows even with mip.mvu still set
    assign irq_target_o = acc.mret  ? mepc_q  :
                          irq_taken ? mtvec_q : '0;

endmodule

// ==== rtl/mvu_csr_bank.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module mvu_csr_bank import csr_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    csr_access_if.slave         acc,
    input  logic [`XLEN-1:0]    mvu_status_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic                hit_o,
    output logic [`XLEN-1:0]    mvu_wbaseptr_o,
    output logic [`XLEN-1:0]    mvu_ibaseptr_o,
    output logic [`XLEN-1:0]    mvu_obaseptr_o,
    output logic [`XLEN-1:0]    mvu_precision_o,
    output logic [`XLEN-1:0]    mvu_quant_o,
    output logic [`XLEN-1:0]    mvu_command_o,
    output logic                mvu_start_o
);

    // read port, status comes straight from the accelerator
    always_comb begin
        hit_o   = 1'b1;
        rdata_o = '0;
        case (acc.addr)
            CSR_MVU_WBASEPTR:  rdata_o = mvu_wbaseptr_o;
            CSR_MVU_IBASEPTR:  rdata_o = mvu_ibaseptr_o;
            CSR_MVU_OBASEPTR:  rdata_o = mvu_obaseptr_o;
            CSR_MVU_PRECISION: rdata_o = mvu_precision_o;
            CSR_MVU_QUANT:     rdata_o = mvu_quant_o;
            CSR_MVU_COMMAND:   rdata_o = mvu_command_o;
            CSR_MVU_STATUS:    rdata_o = mvu_status_i;
            default:           hit_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mvu_wbaseptr_o  <= '0;
            mvu_ibaseptr_o  <= '0;
            mvu_obaseptr_o  <= '0;
            mvu_precision_o <= '0;
            mvu_quant_o     <= '0;
            mvu_command_o   <= '0;
            mvu_start_o     <= 1'b0;
        end else begin
            // one-cycle start after a command write
            mvu_start_o <= acc.we && (acc.addr == CSR_MVU_COMMAND);
            if (acc.we) begin
                case (acc.addr)
                    CSR_MVU_WBASEPTR:  mvu_wbaseptr_o  <= acc.wdata;
                    CSR_MVU_IBASEPTR:  mvu_ibaseptr_o  <= acc.wdata;
                    CSR_MVU_OBASEPTR:  mvu_obaseptr_o  <= acc.wdata;
                    CSR_MVU_PRECISION: mvu_precision_o <= acc.wdata;
                    CSR_MVU_QUANT:     mvu_quant_o     <= acc.wdata;
                    CSR_MVU_COMMAND:   mvu_command_o   <= acc.wdata;
                    default:           mvu_command_o   <= mvu_command_o;
                endcase
            end
        end
    end

endmodule

// ==== rtl/csr_read_mux.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module csr_read_mux (
    csr_access_if.slave         acc,
    input  logic [`XLEN-1:0]    mach_rdata_i,
    input  logic                mach_hit_i,
    input  logic [`XLEN-1:0]    mvu_rdata_i,
    input  logic                mvu_hit_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic                exception_o
);

    logic any_hit;
    logic access;

    assign any_hit = mach_hit_i | mvu_hit_i;
    assign access  = acc.re | acc.we;

    // ========================================
    // merge and illegal access
    // ========================================
    // at most one block hits, the other returns zero
    assign rdata_o = mach_rdata_i | mvu_rdata_i;

    // unknown address during a read or write
    assign exception_o = access & ~any_hit;

endmodule

// ==== rtl/rv32_csr_top.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module rv32_csr_top import csr_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // csr access from the core
    input  logic [2:0]              csr_op_i,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
    input  logic [`XLEN-1:0]        csr_wdata_i,
    output logic [`XLEN-1:0]        csr_rdata_o,
    output logic                    csr_exception_o,
    // trap and counter inputs
    input  logic [`XLEN-1:0]        boot_addr_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [4:0]              cause_i,
    input  logic                    irq_i,
    input  logic                    mvu_irq_i,
    input  logic                    count_en_i,
    output logic                    irq_valid_o,
    output logic [`XLEN-1:0]        irq_target_o,
    // accelerator side
    input  logic [`XLEN-1:0]        mvu_status_i,
    output logic [`XLEN-1:0]        mvu_wbaseptr_o,
    output logic [`XLEN-1:0]        mvu_ibaseptr_o,
    output logic [`XLEN-1:0]        mvu_obaseptr_o,
    output logic [`XLEN-1:0]        mvu_precision_o,
    output logic [`XLEN-1:0]        mvu_quant_o,
    output logic [`XLEN-1:0]        mvu_command_o,
    output logic                    mvu_start_o
);

    csr_op_e            op;
    csr_addr_e          addr;
    logic [`XLEN-1:0]   mach_rdata;
    logic [`XLEN-1:0]   mvu_rdata;
    logic               mach_hit;
    logic               mvu_hit;

    // raw codes onto the enum types, unknown values fall to default
    assign op   = csr_op_e'(csr_op_i);
    assign addr = csr_addr_e'(csr_addr_i);

    csr_access_if acc ();

    csr_op_decode u_decode (
        .op_i       (op),
        .addr_i     (addr),
        .operand_i  (csr_wdata_i),
        .rdata_i    (csr_rdata_o),
        .acc        (acc)
    );

    machine_csr_regs u_mach (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc          (acc),
        .boot_addr_i  (boot_addr_i),
        .pc_i         (pc_i),
        .cause_i      (cause_i),
        .irq_i        (irq_i),
        .mvu_irq_i    (mvu_irq_i),
        .count_en_i   (count_en_i),
        .rdata_o      (mach_rdata),
        .hit_o        (mach_hit),
        .irq_valid_o  (irq_valid_o),
        .irq_target_o (irq_target_o)
    );

    mvu_csr_bank u_mvu (
        .clk             (clk),
        .rst_n           (rst_n),
        .acc             (acc),
        .mvu_status_i    (mvu_status_i),
        .rdata_o         (mvu_rdata),
        .hit_o           (mvu_hit),
        .mvu_wbaseptr_o  (mvu_wbaseptr_o),
        .mvu_ibaseptr_o  (mvu_ibaseptr_o),
        .mvu_obaseptr_o  (mvu_obaseptr_o),
        .mvu_precision_o (mvu_precision_o),
        .mvu_quant_o     (mvu_quant_o),
        .mvu_command_o   (mvu_command_o),
        .mvu_start_o     (mvu_start_o)
    );

    csr_read_mux u_mux (
        .acc          (acc),
        .mach_rdata_i (mach_rdata),
        .mach_hit_i   (mach_hit),
        .mvu_rdata_i  (mvu_rdata),
        .mvu_hit_i    (mvu_hit),
        .rdata_o      (csr_rdata_o),
        .exception_o  (csr_exception_o)
    );

endmodule

// ==== sim/tb_rv32_csr.sv ====
`timescale 1ns/10ps
`include "csr_defines.svh"

module tb_rv32_csr;

    localparam logic [31:0] RAND_SEED  = 32'h03bc_bbb1;
    localparam logic [31:0] BOOT_ADDR  = 32'h0000_8000;
    localparam int          N_RANDOM   = 800;
    localparam int          N_COUNT    = 37;
    // roughly twice the length of all tests together
    localparam int          MAX_CYCLES = 2000;

    logic           clk = 1'b0;
    logic           rst_n;
    logic [2:0]     csr_op_i;
    logic [11:0]    csr_addr_i;
    logic [31:0]    csr_wdata_i;
    logic [31:0]    csr_rdata_o;
    logic           csr_exception_o;
    logic [31:0]    boot_addr_i;
    logic [31:0]    pc_i;
    logic [4:0]     cause_i;
    logic           irq_i;
    logic           mvu_irq_i;
    logic           count_en_i;
    logic           irq_valid_o;
    logic [31:0]    irq_target_o;
    logic [31:0]    mvu_status_i;
    logic [31:0]    mvu_wbaseptr_o;
    logic [31:0]    mvu_ibaseptr_o;
    logic [31:0]    mvu_obaseptr_o;
    logic [31:0]    mvu_precision_o;
    logic [31:0]    mvu_quant_o;
    logic [31:0]    mvu_command_o;
    logic           mvu_start_o;

    // writable registers in model order
    // six mvu registers then mtvec, mtval and mepc
    logic [31:0]    model [0:8] = '{default: '0};
    logic [11:0]    addr_tab [0:8] = '{12'h7C0, 12'h7C1, 12'h7C2, 12'h7C3, 12'h7C4,
                                       12'h7C5, 12'h305, 12'h343, 12'h341};

    string          test_name = "reset";
    logic           chk_rdata = 1'b0;
    logic [31:0]    exp_rdata = '0;
    logic           exp_exc = 1'b0;
    logic           exp_start = 1'b0;
    logic           cmd_wr_q = 1'b0;
    logic           chk_irq = 1'b0;
    logic           exp_valid = 1'b0;
    logic [31:0]    exp_target = '0;
    int             errors = 0;
    int             cycles = 0;
    int             idx;
    logic [2:0]     op;
    logic [11:0]    addr_v;
    logic [31:0]    base;
    logic [31:0]    status_v;

    rv32_csr_top uut (.*);

    always #4 clk = ~clk;

    // ========================================
    // reference model
    // ========================================
    function automatic logic [31:0] ref_csr(input logic [11:0] addr, input logic [2:0] op_v,
            input logic [31:0] operand, input logic [31:0] cur, output logic [31:0] nxt);
        case (op_v)
            3'd1:    nxt = operand;
            3'd2:    nxt = cur | operand;
            3'd3:    nxt = cur & ~operand;
            default: nxt = cur;
        endcase
        // mepc never holds an odd address
        if (addr == 12'h341) begin
            nxt[0] = 1'b0;
        end
        return cur;
    endfunction

    function automatic logic known_addr(input logic [11:0] a);
        case (a)
            12'h300, 12'h301, 12'h304, 12'h305, 12'h341, 12'h342, 12'h343, 12'h344,
            12'hB00, 12'hB80, 12'hF11, 12'hF12, 12'hF13, 12'hF14: return 1'b1;
            default: return (a >= 12'h7C0) && (a <= 12'h7C6);
        endcase
    endfunction

    function automatic logic [31:0] id_value(input logic [11:0] a);
        case (a)
            12'h301: return `ISA_CODE;
            12'hF12: return `MARCHID;
            12'hF14: return `HART_ID;
            // vendor and impl id read as zero
            default: return '0;
        endcase
    endfunction

    task automatic report_err(input string what, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    // drives one op for one cycle from a rising edge
    task automatic do_op(input string name, input logic [2:0] op_v, input logic [11:0] addr,
            input logic [31:0] wdata, input logic chk, input logic [31:0] exp);
        test_name = name;
        chk_rdata = chk;
        exp_rdata = exp;
        exp_exc   = (op_v inside {3'd1, 3'd2, 3'd3}) && !known_addr(addr);
        csr_op_i    <= op_v;
        csr_addr_i  <= addr;
        csr_wdata_i <= wdata;
        @(posedge clk);
    endtask

    task automatic model_access(input string name, input logic [2:0] op_v, input int i,
            input logic [31:0] operand);
        logic [31:0] exp;
        logic [31:0] nxt;
        exp = ref_csr(addr_tab[i], op_v, operand, model[i], nxt);
        do_op(name, op_v, addr_tab[i], operand, 1'b1, exp);
        model[i] = nxt;
    endtask

    // ========================================
    // compare mid-cycle on the falling edge
    // ========================================
    always @(negedge clk) begin
        if (rst_n) begin
            if (chk_rdata && csr_rdata_o !== exp_rdata) begin
                report_err("rdata", exp_rdata, csr_rdata_o);
            end
            if (csr_exception_o !== exp_exc) begin
                report_err("exception", 32'(exp_exc), 32'(csr_exception_o));
            end
            // start follows a command write by one cycle
            exp_start = cmd_wr_q;
            cmd_wr_q  = (csr_op_i inside {3'd1, 3'd2, 3'd3}) && (csr_addr_i == 12'h7C5);
            if (mvu_start_o !== exp_start) begin
                report_err("mvu_start", 32'(exp_start), 32'(mvu_start_o));
            end
            if (chk_irq && irq_valid_o !== exp_valid) begin
                report_err("irq_valid", 32'(exp_valid), 32'(irq_valid_o));
            end
            if (chk_irq && irq_target_o !== exp_target) begin
                report_err("irq_target", exp_target, irq_target_o);
            end
            if (mvu_wbaseptr_o !== model[0]) report_err("wbaseptr", model[0], mvu_wbaseptr_o);
            if (mvu_ibaseptr_o !== model[1]) report_err("ibaseptr", model[1], mvu_ibaseptr_o);
            if (mvu_obaseptr_o !== model[2]) report_err("obaseptr", model[2], mvu_obaseptr_o);
            if (mvu_precision_o !== model[3]) report_err("precision", model[3], mvu_precision_o);
            if (mvu_quant_o !== model[4]) report_err("quant", model[4], mvu_quant_o);
            if (mvu_command_o !== model[5]) report_err("command", model[5], mvu_command_o);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not complete within %0d cycles", MAX_CYCLES);
            $display("run stopped, %0d errors in %0d cycles", errors, cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin
        void'($urandom(RAND_SEED));
        rst_n        = 1'b0;
        csr_op_i     = '0;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        boot_addr_i  = BOOT_ADDR;
        pc_i         = '0;
        cause_i      = '0;
        irq_i        = 1'b0;
        mvu_irq_i    = 1'b0;
        count_en_i   = 1'b0;
        mvu_status_i = '0;
        model[6]     = BOOT_ADDR;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        do_op("idle", 3'd0, 12'h300, '0, 1'b0, '0);

        // reset values
        model_access("reset_mtvec", 3'd0, 6, '0);
        do_op("reset_mstatus", 3'd0, 12'h300, '0, 1'b1, '0);
        do_op("reset_mie", 3'd0, 12'h304, '0, 1'b1, '0);
        do_op("reset_mip", 3'd0, 12'h344, '0, 1'b1, '0);

        // misa and the id registers ignore writes
        for (idx = 0; idx < 5; idx++) begin
            addr_v = (idx == 0) ? 12'h301 : 12'(12'hF10 + idx);
            do_op("ident_write", 3'd1, addr_v, $urandom, 1'b1, id_value(addr_v));
            do_op("ident_read", 3'd0, addr_v, '0, 1'b1, id_value(addr_v));
        end

        // every op code on unknown addresses
        for (idx = 0; idx < 8; idx++) begin
            addr_v = idx[0] ? 12'h123 : 12'h7C7;
            do_op("illegal_addr", idx[2:0], addr_v, $urandom, 1'b1, '0);
        end

        for (idx = 0; idx < N_RANDOM; idx++) begin
            op = 3'($urandom_range(3, 1));
            base = $urandom_range(9, 0);
            if (base == 32'd9) begin
                addr_v = 12'h7C6;
                status_v = $urandom;
                mvu_status_i <= status_v;
                do_op("random_status", op, addr_v, $urandom, 1'b1, status_v);
            end else begin
                model_access("random", op, int'(base), $urandom);
            end
        end

        model_access("start_write", 3'd1, 5, $urandom);
        do_op("start_after_write", 3'd0, 12'h300, '0, 1'b0, '0);
        do_op("start_read", 3'd0, 12'h7C5, '0, 1'b1, model[5]);
        do_op("start_after_read", 3'd0, 12'h300, '0, 1'b0, '0);

        // interrupt entry and return
        // mpie is still set from the mret in the unknown address loop
        do_op("irq_mie", 3'd1, 12'h304, 32'h0001_0000, 1'b1, '0);
        do_op("irq_mstatus", 3'd1, 12'h300, 32'h0000_0008, 1'b1, 32'h0000_0080);
        pc_i      <= 32'h0000_1a2c;
        cause_i   <= 5'd16;
        mvu_irq_i <= 1'b1;
        do_op("irq_pulse", 3'd0, 12'h344, '0, 1'b1, '0);
        mvu_irq_i <= 1'b0;
        chk_irq    = 1'b1;
        exp_valid  = 1'b1;
        exp_target = model[6];
        do_op("irq_mip", 3'd0, 12'h344, '0, 1'b1, 32'h0001_0000);
        pc_i <= 32'h0000_2000;
        do_op("irq_mcause", 3'd0, 12'h342, '0, 1'b1, 32'h8000_0010);
        do_op("irq_mepc", 3'd0, 12'h341, '0, 1'b1, 32'h0000_1a2c);
        do_op("irq_clear_mie", 3'd3, 12'h300, 32'h0000_0008, 1'b1, 32'h0000_0088);
        exp_valid  = 1'b0;
        exp_target = 32'h0000_1a2c;
        do_op("irq_mret", 3'd4, 12'h300, '0, 1'b1, 32'h0000_0080);
        chk_irq = 1'b0;
        do_op("irq_restored", 3'd0, 12'h300, '0, 1'b1, 32'h0000_0088);
        do_op("irq_mip_clear", 3'd1, 12'h344, '0, 1'b1, 32'h0001_0000);
        do_op("irq_mip_read", 3'd0, 12'h344, '0, 1'b1, '0);

        // cycle counter has been idle since reset
        do_op("cycle_base", 3'd0, 12'hB00, '0, 1'b1, '0);
        count_en_i <= 1'b1;
        for (idx = 0; idx < N_COUNT; idx++) begin
            do_op("cycle_count", 3'd0, 12'hB00, '0, 1'b1, 32'(idx));
        end
        count_en_i <= 1'b0;
        do_op("cycle_read", 3'd0, 12'hB00, '0, 1'b1, 32'(N_COUNT));
        do_op("cycle_high", 3'd0, 12'hB80, '0, 1'b1, '0);

        $display("run complete, %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_access_if.sv
rtl/csr_op_decode.sv
rtl/machine_csr_regs.sv
rtl/mvu_csr_bank.sv
rtl/csr_read_mux.sv
rtl/rv32_csr_top.sv
sim/tb_rv32_csr.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim_run.log

verilator --binary --timing --timescale 1ns/10ps -f files.f \
    --top-module tb_rv32_csr --Mdir "$BUILD_DIR" -o tb_rv32_csr
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/tb_rv32_csr" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0
